// ==== rtl/rv_core_pkg.sv ====
////////////////////
// Sizes, opcodes, ALU and branch encodings
// and the instruction word type of the RV32I core
////////////////////

package rv_core_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int XLEN    = 32;
    localparam int ILEN    = 32;
    localparam int REG_AW  = 5;
    localparam int NB_REGS = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // First fetch address out of reset
    localparam xlen_t BOOT_ADDR = 32'h0000_0000;

    ////////////////////
    // Major opcodes
    ////////////////////

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // Branch conditions, always is used by JAL
    typedef enum logic [2:0] {
        BR_NEVER,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_ALWAYS
    } br_cond_t;

    // One instruction word, seen as R-type or as I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i;
    } instr_t;

endpackage

// ==== rtl/rv_regfile.sv ====
////////////////////
// Integer register file, x0 reads as zero
////////////////////

`timescale 1ns/10ps

module rv_regfile (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  rv_core_pkg::reg_addr_t rs1_addr,
    input  rv_core_pkg::reg_addr_t rs2_addr,
    input  rv_core_pkg::reg_addr_t rd_addr,
    input  rv_core_pkg::reg_addr_t dbg_addr,
    input  logic                  rd_wr,
    input  logic                  wr_en,
    input  rv_core_pkg::xlen_t     result,
    output rv_core_pkg::xlen_t     rs1_val,
    output rv_core_pkg::xlen_t     rs2_val,
    output rv_core_pkg::xlen_t     dbg_val
);

    import rv_core_pkg::*;

    // x1 to x31, x0 has no storage
    xlen_t [NB_REGS-1:1] regs;

    function automatic xlen_t read_reg(input reg_addr_t addr);
        xlen_t val;
        val = (addr == '0) ? '0 : regs[addr];
        return val;
    endfunction

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_en && rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= result;
        end
    end

    // Three combinational read ports
    assign rs1_val = read_reg(rs1_addr);
    assign rs2_val = read_reg(rs2_addr);
    assign dbg_val = read_reg(dbg_addr);

    ////////////////////
    // Assertions
    ////////////////////

    // A retiring write aimed at x0 leaves the whole file untouched
    a_x0_write_dropped: assert property (
        @(posedge aclk) disable iff (!rst_n)
        wr_en && rd_wr && rd_addr == '0 |=> $stable(regs)
    );

endmodule

// ==== rtl/rv_decode.sv ====
////////////////////
// Instruction decoder, register fields,
// immediates and ALU / branch controls
////////////////////

`timescale 1ns/10ps

module rv_decode (
    input  rv_core_pkg::instr_t    instr,
    output rv_core_pkg::reg_addr_t rs1_addr,
    output rv_core_pkg::reg_addr_t rs2_addr,
    output rv_core_pkg::reg_addr_t rd_addr,
    output logic                   rd_wr,
    output rv_core_pkg::xlen_t     imm,
    output logic                   use_imm,
    output logic                   use_pc,
    output rv_core_pkg::alu_op_t   alu_op,
    output rv_core_pkg::br_cond_t  br_cond
);

    import rv_core_pkg::*;

    logic [ILEN-1:0] word;
    xlen_t           imm_i;
    xlen_t           imm_u;
    xlen_t           imm_j;
    xlen_t           imm_b;

    // Shared funct3 mapping, alt picks sub or sra
    function automatic alu_op_t op_from_funct3(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign word = instr;

    assign rs1_addr = instr.i.rs1;
    assign rs2_addr = instr.r.rs2;
    assign rd_addr  = instr.i.rd;

    ////////////////////
    // Immediates
    ////////////////////

    assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    assign imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};

    always_comb begin
        rd_wr   = 1'b0;
        imm     = imm_i;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        alu_op  = ALU_ADD;
        br_cond = BR_NEVER;
        case (instr.r.opcode)
            OPC_LUI: begin
                rd_wr   = 1'b1;
                imm     = imm_u;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                rd_wr   = 1'b1;
                imm     = imm_u;
                use_imm = 1'b1;
                use_pc  = 1'b1;
            end
            OPC_JAL: begin
                rd_wr   = 1'b1;
                imm     = imm_j;
                br_cond = BR_ALWAYS;
            end
            OPC_BRANCH: begin
                imm = imm_b;
                case (instr.r.funct3)
                    3'b000:  br_cond = BR_EQ;
                    3'b001:  br_cond = BR_NE;
                    3'b100:  br_cond = BR_LT;
                    3'b101:  br_cond = BR_GE;
                    default: br_cond = BR_NEVER;
                endcase
            end
            OPC_OP_IMM: begin
                rd_wr   = 1'b1;
                use_imm = 1'b1;
                // Only SRAI carries the alternate bit in its immediate
                alu_op  = op_from_funct3(instr.i.funct3,
                                         instr.i.funct3 == 3'b101 && instr.i.imm12[10]);
            end
            OPC_OP: begin
                rd_wr  = 1'b1;
                alu_op = op_from_funct3(instr.r.funct3, instr.r.funct7[5]);
            end
            default: begin
                // Unsupported opcodes retire as no-ops
                rd_wr = 1'b0;
            end
        endcase
    end

endmodule

// ==== rtl/rv_alu.sv ====
////////////////////
// Integer ALU and branch comparator
////////////////////

`timescale 1ns/10ps

module rv_alu (
    input  rv_core_pkg::xlen_t    rs1_val,
    input  rv_core_pkg::xlen_t    rs2_val,
    input  rv_core_pkg::xlen_t    imm,
    input  rv_core_pkg::xlen_t    pc,
    input  logic                  use_imm,
    input  logic                  use_pc,
    input  rv_core_pkg::alu_op_t  alu_op,
    input  rv_core_pkg::br_cond_t br_cond,
    output rv_core_pkg::xlen_t    result,
    output logic                  taken
);

    import rv_core_pkg::*;

    xlen_t      op_a;
    xlen_t      op_b;
    xlen_t      alu_out;
    logic [4:0] shamt;

    ////////////////////
    // Operand select
    ////////////////////

    assign op_a  = use_pc ? pc : rs1_val;
    assign op_b  = use_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // JAL links the address of the next instruction
    assign result = (br_cond == BR_ALWAYS) ? pc + 32'd4 : alu_out;

    ////////////////////
    // Branch decision
    ////////////////////

    always_comb begin
        case (br_cond)
            BR_EQ:     taken = (rs1_val == rs2_val);
            BR_NE:     taken = (rs1_val != rs2_val);
            BR_LT:     taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:     taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

endmodule

// ==== rtl/rv_control.sv ====
////////////////////
// Fetch / execute sequencer with pc,
// instruction register and AXI4-lite read master
////////////////////

`timescale 1ns/10ps

module rv_control (
    input  logic                aclk,
    input  logic                rst_n,
    // Instruction memory read channel
    output logic                arvalid,
    input  logic                arready,
    output rv_core_pkg::xlen_t  araddr,
    input  logic                rvalid,
    output logic                rready,
    input  rv_core_pkg::xlen_t  rdata,
    // Towards decode and ALU
    output rv_core_pkg::instr_t instr,
    input  rv_core_pkg::xlen_t  imm,
    input  logic                taken,
    output logic                wr_en,
    output logic                retired,
    output rv_core_pkg::xlen_t  pc
);

    import rv_core_pkg::*;

    // One-hot sequence, fetch is arvalid, wait is rready
    logic   exec;
    instr_t ir;
    xlen_t  pc_next;

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
            exec    <= 1'b0;
            pc      <= BOOT_ADDR;
        end else begin
            if (exec) begin
                // Single execute cycle, next fetch starts right after
                exec    <= 1'b0;
                arvalid <= 1'b1;
                pc      <= pc_next;
            end else if (rready) begin
                if (rvalid) begin
                    rready <= 1'b0;
                    exec   <= 1'b1;
                end
            end else if (arvalid) begin
                if (arready) begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                end
            end else begin
                // First cycle out of reset
                arvalid <= 1'b1;
            end
        end
    end

    // Instruction register, loaded on the read data handshake
    always_ff @(posedge aclk) begin
        if (rready && rvalid) begin
            ir <= rdata;
        end
    end

    // Taken branches and JAL jump pc-relative
    assign pc_next = taken ? pc + imm : pc + 32'd4;

    assign araddr  = pc;
    assign instr   = ir;
    assign wr_en   = exec;
    assign retired = exec;

    ////////////////////
    // Assertions
    ////////////////////

    // Address phase is held until accepted
    a_ar_hold: assert property (
        @(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr)
    );

    a_retired_pulse: assert property (
        @(posedge aclk) disable iff (!rst_n)
        retired |=> !retired
    );

    // Word aligned fetch addresses only
    a_pc_aligned: assert property (
        @(posedge aclk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    );

endmodule

// ==== rtl/rv_core.sv ====
////////////////////
// RV32I core top level
////////////////////

`timescale 1ns/10ps

module rv_core (
    input  logic                   aclk,
    input  logic                   rst_n,
    // Instruction memory, AXI4-lite read channel
    output logic                   arvalid,
    input  logic                   arready,
    output rv_core_pkg::xlen_t     araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  rv_core_pkg::xlen_t     rdata,
    // Debug access
    input  rv_core_pkg::reg_addr_t dbg_addr,
    output rv_core_pkg::xlen_t     dbg_val,
    output rv_core_pkg::xlen_t     pc,
    output logic                   retired
);

    import rv_core_pkg::*;

    instr_t    instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      rd_wr;
    logic      use_imm;
    logic      use_pc;
    logic      wr_en;
    logic      taken;
    xlen_t     imm;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    xlen_t     result;
    alu_op_t   alu_op;
    br_cond_t  br_cond;

    ////////////////////
    // Sequencer
    ////////////////////

    rv_control control (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .instr   (instr),
        .imm     (imm),
        .taken   (taken),
        .wr_en   (wr_en),
        .retired (retired),
        .pc      (pc)
    );

    rv_decode decode (
        .instr    (instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_wr    (rd_wr),
        .imm      (imm),
        .use_imm  (use_imm),
        .use_pc   (use_pc),
        .alu_op   (alu_op),
        .br_cond  (br_cond)
    );

    ////////////////////
    // Execute
    ////////////////////

    rv_alu alu (
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .imm     (imm),
        .pc      (pc),
        .use_imm (use_imm),
        .use_pc  (use_pc),
        .alu_op  (alu_op),
        .br_cond (br_cond),
        .result  (result),
        .taken   (taken)
    );

    rv_regfile isa_registers (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .dbg_addr (dbg_addr),
        .rd_wr    (rd_wr),
        .wr_en    (wr_en),
        .result   (result),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .dbg_val  (dbg_val)
    );

endmodule

// ==== verif/tb_imem.sv ====
////////////////////
// Instruction memory model serving the AXI4-lite read channel with random stalls
////////////////////

`timescale 1ns/10ps

module tb_imem (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               arvalid,
    output logic               arready,
    input  rv_core_pkg::xlen_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output rv_core_pkg::xlen_t rdata,
    input  rv_core_pkg::xlen_t prog [0:63]
);

    import rv_core_pkg::*;

    logic [31:0] rng_state = 32'h7f90;
    logic [1:0]  ar_stall;
    logic [1:0]  r_stall;
    logic        ar_armed;
    logic        r_pending;
    xlen_t       req_addr;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Outside the 64 words the opcode field is zero, which the core treats as a no-op
    function automatic xlen_t read_word(input xlen_t addr);
        xlen_t word;
        if (addr[31:8] == '0) begin
            word = prog[addr[7:2]];
        end else begin
            word = {addr[26:2] ^ addr[31:7], 7'b0000000};
        end
        return word;
    endfunction

    always @(negedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rdata     <= '0;
            ar_stall  = '0;
            r_stall   = '0;
            ar_armed  = 1'b0;
            r_pending = 1'b0;
            req_addr  = '0;
        end else begin
            // Address phase
            if (arready) begin
                // Accepted on the rising edge just passed
                arready   <= 1'b0;
                rng_state = xorshift32(rng_state);
                r_stall   = rng_state[1:0];
                r_pending = 1'b1;
            end else if (arvalid) begin
                if (!ar_armed) begin
                    rng_state = xorshift32(rng_state);
                    ar_stall  = rng_state[1:0];
                    ar_armed  = 1'b1;
                end
                if (ar_stall == 2'd0) begin
                    arready  <= 1'b1;
                    req_addr = araddr;
                    ar_armed = 1'b0;
                end else begin
                    ar_stall = ar_stall - 2'd1;
                end
            end
            // Data phase
            if (rvalid) begin
                rvalid <= 1'b0;
            end else if (r_pending && rready) begin
                if (r_stall == 2'd0) begin
                    rvalid    <= 1'b1;
                    rdata     <= read_word(req_addr);
                    r_pending = 1'b0;
                end else begin
                    r_stall = r_stall - 2'd1;
                end
            end
        end
    end

endmodule

// ==== verif/tb_rv_core.sv ====
////////////////////
// Testbench for the RV32I core with program and check tables,
// compare tasks, watchdog and report
////////////////////

`timescale 1ns/10ps

module tb_rv_core;

    import rv_core_pkg::*;

    localparam int CLK_PERIOD = 40;

    // Operands loaded into x1 and x2
    localparam xlen_t OPND_A = 32'd5;
    localparam xlen_t OPND_B = 32'hFFFF_FFFD;

    logic      aclk = 1'b0;
    logic      rst_n;
    logic      arvalid;
    logic      arready;
    xlen_t     araddr;
    logic      rvalid;
    logic      rready;
    xlen_t     rdata;
    reg_addr_t dbg_addr;
    xlen_t     dbg_val;
    xlen_t     pc;
    logic      retired;

    xlen_t     prog_mem [0:63];
    xlen_t     prog_q [$];
    string     chk_name [$];
    reg_addr_t chk_reg [$];
    xlen_t     chk_exp [$];
    logic      prog_ready = 1'b0;
    int        pass_count = 0;
    int        fail_count = 0;
    xlen_t     auipc_pc;
    xlen_t     jal_pc;
    xlen_t     loop_pc;

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    rv_core dut (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .dbg_addr (dbg_addr),
        .dbg_val  (dbg_val),
        .pc       (pc),
        .retired  (retired)
    );

    tb_imem imem (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .prog    (prog_mem)
    );

    ////////////////////
    // Instruction encoders
    ////////////////////

    function automatic xlen_t enc_r(input logic [6:0] funct7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] funct3,
                                    input reg_addr_t rd);
        instr_t w;
        w.r.funct7 = funct7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = funct3;
        w.r.rd     = rd;
        w.r.opcode = OPC_OP;
        return w;
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm12, input reg_addr_t rs1,
                                    input logic [2:0] funct3, input reg_addr_t rd,
                                    input logic [6:0] opcode);
        instr_t w;
        w.i.imm12  = imm12;
        w.i.rs1    = rs1;
        w.i.funct3 = funct3;
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    // Upper immediate spans the imm12, rs1 and funct3 fields
    function automatic xlen_t enc_u(input logic [19:0] imm20, input reg_addr_t rd,
                                    input logic [6:0] opcode);
        instr_t w;
        w.i.imm12  = imm20[19:8];
        w.i.rs1    = imm20[7:3];
        w.i.funct3 = imm20[2:0];
        w.i.rd     = rd;
        w.i.opcode = opcode;
        return w;
    endfunction

    function automatic xlen_t enc_b(input logic [2:0] funct3, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [12:0] off);
        instr_t w;
        w.r.funct7 = {off[12], off[10:5]};
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = funct3;
        w.r.rd     = {off[4:1], off[11]};
        w.r.opcode = OPC_BRANCH;
        return w;
    endfunction

    function automatic xlen_t enc_j(input reg_addr_t rd, input logic [20:0] off);
        instr_t w;
        w.i.imm12  = {off[20], off[10:1], off[11]};
        w.i.rs1    = off[19:15];
        w.i.funct3 = off[14:12];
        w.i.rd     = rd;
        w.i.opcode = OPC_JAL;
        return w;
    endfunction

    ////////////////////
    // Program and check tables
    ////////////////////

    task automatic add_check(input string name, input reg_addr_t r, input xlen_t exp);
        chk_name.push_back(name);
        chk_reg.push_back(r);
        chk_exp.push_back(exp);
    endtask

    task automatic build_program();
        prog_q.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        prog_q.push_back(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog_q.push_back(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd5));
        prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog_q.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7));
        prog_q.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd8));
        // srai x9, x2, 1
        prog_q.push_back(enc_i(12'h401, 5'd2, 3'b101, 5'd9, OPC_OP_IMM));
        prog_q.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd10));
        prog_q.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd11));
        prog_q.push_back(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd12));
        prog_q.push_back(enc_i(12'd6, 5'd1, 3'b010, 5'd13, OPC_OP_IMM));
        prog_q.push_back(enc_i(12'h0ff, 5'd1, 3'b100, 5'd14, OPC_OP_IMM));
        prog_q.push_back(enc_u(20'h12345, 5'd15, OPC_LUI));
        auipc_pc = prog_q.size() * 4;
        prog_q.push_back(enc_u(20'h00001, 5'd16, OPC_AUIPC));
        prog_q.push_back(enc_i(12'd7, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
        // Taken branches skip an x20 increment and fall-throughs bump x21
        prog_q.push_back(enc_b(3'b000, 5'd1, 5'd1, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd21, 3'b000, 5'd21, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b001, 5'd1, 5'd1, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd21, 3'b000, 5'd21, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b100, 5'd2, 5'd1, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b100, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd21, 3'b000, 5'd21, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b101, 5'd1, 5'd2, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        prog_q.push_back(enc_b(3'b101, 5'd2, 5'd1, 13'd8));
        prog_q.push_back(enc_i(12'd1, 5'd21, 3'b000, 5'd21, OPC_OP_IMM));
        // jal x22 over two wrong-path increments
        jal_pc = prog_q.size() * 4;
        prog_q.push_back(enc_j(5'd22, 21'd12));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        prog_q.push_back(enc_i(12'd1, 5'd20, 3'b000, 5'd20, OPC_OP_IMM));
        // lw x23, 4(x1) has no load unit here
        prog_q.push_back(enc_i(12'd4, 5'd1, 3'b010, 5'd23, 7'b0000011));
        prog_q.push_back(enc_i(12'd10, 5'd21, 3'b000, 5'd24, OPC_OP_IMM));
        loop_pc = prog_q.size() * 4;
        prog_q.push_back(enc_j(5'd0, 21'd0));
    endtask

    task automatic build_checks();
        add_check("addi_pos", 5'd1, OPND_A);
        add_check("addi_neg", 5'd2, OPND_B);
        add_check("add", 5'd3, OPND_A + OPND_B);
        add_check("sub", 5'd4, OPND_A - OPND_B);
        add_check("xor", 5'd5, OPND_A ^ OPND_B);
        add_check("or", 5'd6, OPND_A | OPND_B);
        add_check("and", 5'd7, OPND_A & OPND_B);
        add_check("sll", 5'd8, OPND_A << 5);
        // -3 shifted right arithmetically by one is -2
        add_check("srai_neg", 5'd9, 32'hFFFF_FFFE);
        add_check("srl", 5'd10, OPND_B >> 5);
        add_check("slt", 5'd11, 32'd1);
        add_check("sltu", 5'd12, 32'd0);
        add_check("slti", 5'd13, 32'd1);
        add_check("xori", 5'd14, OPND_A ^ 32'h0000_00ff);
        add_check("lui", 5'd15, 32'h1234_5000);
        add_check("auipc", 5'd16, auipc_pc + 32'h0000_1000);
        add_check("x0_write", 5'd0, 32'd0);
        add_check("branch_skip", 5'd20, 32'd0);
        add_check("branch_fall", 5'd21, 32'd4);
        add_check("jal_link", 5'd22, jal_pc + 32'd4);
        add_check("unsupported_op", 5'd23, 32'd0);
        add_check("after_no_op", 5'd24, 32'd14);
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_reg(input string name, input xlen_t expected, input xlen_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("ok     %s = 0x%08h", name, actual);
        end else begin
            fail_count++;
            $display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_pc(input string name, input xlen_t expected, input xlen_t actual);
        if (actual === expected) begin
            pass_count++;
            $display("ok     %s pc = 0x%08h", name, actual);
        end else begin
            fail_count++;
            $display("FAILED %s expected pc 0x%08h actual pc 0x%08h", name, expected, actual);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int    n_retired;
        int    loop_hits;
        xlen_t last_pc;
        rst_n    = 1'b0;
        dbg_addr = '0;
        build_program();
        build_checks();
        // Unused words get an opcode of zero tagged with their index
        for (int i = 0; i < 64; i++) begin
            prog_mem[i] = (i < prog_q.size()) ? prog_q[i] : {i[24:0], 7'b0000000};
        end
        prog_ready = 1'b1;
        repeat (5) @(negedge aclk);
        rst_n = 1'b1;

        // Follow retirements until the pc stops moving on a self-loop
        n_retired = 0;
        loop_hits = 0;
        last_pc   = BOOT_ADDR;
        while (loop_hits < 2) begin
            @(negedge aclk);
            if (retired) begin
                @(negedge aclk);
                n_retired++;
                loop_hits = (pc == last_pc) ? loop_hits + 1 : 0;
                last_pc   = pc;
            end
        end
        $display("core reached the self-loop after %0d instructions", n_retired);
        check_pc("final_pc", loop_pc, pc);

        for (int i = 0; i < chk_name.size(); i++) begin
            dbg_addr = chk_reg[i];
            @(negedge aclk);
            check_reg(chk_name[i], chk_exp[i], dbg_val);
        end

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the program length
    initial begin
        wait (prog_ready);
        repeat (prog_q.size() * 8 + 50) @(posedge aclk);
        $display("Watchdog expired: the core did not reach the self-loop and finish the checks");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/rv_core_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_control.sv
rtl/rv_core.sv
verif/tb_imem.sv
verif/tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_rv_core
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
